// File: dma_cfg_pkg.sv
// ####################
// packet DMA configuration
// beat and line widths, tag codes, line geometry
// ####################

package dma_cfg_pkg;

  // SRAM line and packet beat widths
  localparam int LINE_W         = 256;
  localparam int BEAT_W         = 128;
  localparam int PKT_W          = 134;

  // 32-bit words per line and per beat
  localparam int WORDS_PER_LINE = 8;
  localparam int WORDS_PER_BEAT = 4;
  localparam int BYTES_PER_BEAT = BEAT_W / 8;

  // byte address split: line index, word in line, byte in word
  localparam int WORD_IDX_W     = $clog2(WORDS_PER_LINE);
  localparam int LINE_IDX_W     = 32 - WORD_IDX_W - 2;

  // beat tags in bits 133:132
  localparam logic [1:0] TAG_HEAD = 2'b11;
  localparam logic [1:0] TAG_BODY = 2'b01;
  localparam logic [1:0] TAG_TAIL = 2'b10;

  // cnt on input: [3:2] = valid words - 1
  // cnt on output: valid bytes - 1
  // data byte 0 sits in the top byte
  typedef struct packed {
    logic [1:0]        tag;
    logic [3:0]        cnt;
    logic [BEAT_W-1:0] data;
  } pkt_beat_t;

endpackage

// File: dma_desc_pkg.sv
// ####################
// DMA descriptor types
// byte address views, descriptor and interrupt word
// ####################

package dma_desc_pkg;
  import dma_cfg_pkg::*;

  // one byte address, read raw or as line / word / byte
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [LINE_IDX_W-1:0] line;
      logic [WORD_IDX_W-1:0] word;
      logic [1:0]            bsel;
    } f;
  } dma_addr_u;

  // 48-bit descriptor, low 48 bits of a read FIFO entry
  typedef struct packed {
    logic [15:0] len;
    dma_addr_u   addr;
  } dma_desc_t;

  // completion word, bit 31 set for a write job
  typedef struct packed {
    logic        wr_flag;
    logic [30:0] addr;
  } int_word_t;

endpackage

// File: sram_req_if.sv
// ####################
// engine to arbiter SRAM request bus
// ####################

`timescale 1ns/100ps

interface sram_req_if import dma_cfg_pkg::*; ();

  // driven by the engine
  logic                      req;
  logic                      rden;
  logic                      wren;
  logic [LINE_IDX_W-1:0]     addr;
  logic [LINE_W-1:0]         wdata;
  logic [WORDS_PER_LINE-1:0] wstrb;
  logic [WORDS_PER_LINE-1:0] winc;
  logic                      done;
  logic [30:0]               int_addr;

  // driven by the arbiter
  logic                      gnt;
  logic [LINE_W-1:0]         rdata;
  logic                      rvalid;

  modport engine (
    output req, rden, wren, addr, wdata, wstrb, winc, done, int_addr,
    input  gnt, rdata, rvalid
  );

  modport arbiter (
    input  req, rden, wren, addr, wdata, wstrb, winc, done, int_addr,
    output gnt, rdata, rvalid
  );

endinterface

// File: dma_wr_engine.sv
// ####################
// DMA write engine
// stores head-tagged packets at the descriptor address
// ####################

`timescale 1ns/100ps

module dma_wr_engine import dma_cfg_pkg::*, dma_desc_pkg::*; (
   input  logic          i_clk
  ,input  logic          i_rst_n
  ,input  logic          i_empty_data
  ,output logic          o_data_rden
  ,input  pkt_beat_t     i_data
  ,input  dma_desc_t     i_wr_desc
  ,input  logic          i_wr_desc_empty
  ,output logic          o_wr_desc_rden
  ,sram_req_if.engine    bus
);

  typedef enum logic [1:0] {WR_IDLE, WR_WRITE, WR_DISCARD} wr_state_t;

  wr_state_t                   state;
  logic                        first_beat;
  logic                        tail_sent;
  logic [LINE_IDX_W-1:0]       line_q;
  logic [WORD_IDX_W-1:0]       slot_q;
  logic [LINE_IDX_W-1:0]       line_cur;
  logic [WORD_IDX_W-1:0]       slot_cur;
  logic [WORD_IDX_W:0]         slot_sum;
  logic                        pop;
  logic                        beat_wr;
  logic [BEAT_W-1:0]           beat_le;
  logic [2*LINE_W-1:0]         line_dbl;
  logic [WORDS_PER_BEAT-1:0]   word_vld;
  logic [2*WORDS_PER_LINE-1:0] strb_dbl;
  logic [WORDS_PER_LINE-1:0]   strb_rot;
  logic [WORDS_PER_LINE-1:0]   wrap_mask;

  // pop only when a beat is there
  always_comb begin
    case (state)
      WR_WRITE:   pop = bus.gnt && !tail_sent && !i_empty_data;
      WR_DISCARD: pop = !i_empty_data;
      default:    pop = 1'b0;
    endcase
  end

  assign beat_wr        = pop && (state == WR_WRITE);
  assign o_data_rden    = pop;
  assign o_wr_desc_rden = beat_wr && first_beat;

  // first beat takes its slot straight from the descriptor
  assign line_cur = first_beat ? i_wr_desc.addr.f.line : line_q;
  assign slot_cur = first_beat ? i_wr_desc.addr.f.word : slot_q;
  assign slot_sum = {1'b0, slot_cur} + (WORD_IDX_W+1)'(WORDS_PER_BEAT);

  // packet byte 0 to the lowest memory byte
  always_comb begin
    for (int b = 0; b < BEAT_W/8; b++) begin
      beat_le[8*b +: 8] = i_data.data[BEAT_W-8-8*b +: 8];
    end
    for (int k = 0; k < WORDS_PER_BEAT; k++) begin
      word_vld[k] = (k <= int'(i_data.cnt[3:2]));
    end
  end

  // rotate the four words to the slot with wrap around the line
  assign line_dbl = {{(LINE_W-BEAT_W){1'b0}}, beat_le,
                     {(LINE_W-BEAT_W){1'b0}}, beat_le} << (32 * slot_cur);
  assign strb_dbl = {{(WORDS_PER_LINE-WORDS_PER_BEAT){1'b0}}, word_vld,
                     {(WORDS_PER_LINE-WORDS_PER_BEAT){1'b0}}, word_vld} << slot_cur;
  assign strb_rot  = strb_dbl[2*WORDS_PER_LINE-1 -: WORDS_PER_LINE];
  // words below the slot belong to the next line
  assign wrap_mask = (WORDS_PER_LINE'(1) << slot_cur) - WORDS_PER_LINE'(1);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state      <= WR_IDLE;
      bus.req    <= 1'b0;
      bus.wren   <= 1'b0;
      bus.done   <= 1'b0;
      first_beat <= 1'b0;
      tail_sent  <= 1'b0;
      line_q     <= '0;
      slot_q     <= '0;
    end else begin
      bus.wren <= beat_wr;
      bus.done <= 1'b0;
      case (state)
        WR_IDLE: begin
          if (bus.req) begin
            // port released one cycle after done
            bus.req <= 1'b0;
          end else if (!i_empty_data) begin
            if (i_data.tag != TAG_HEAD) begin
              state <= WR_DISCARD;
            end else if (!i_wr_desc_empty) begin
              bus.req    <= 1'b1;
              first_beat <= 1'b1;
              tail_sent  <= 1'b0;
              state      <= WR_WRITE;
            end
          end
        end
        WR_WRITE: begin
          if (tail_sent) begin
            bus.done <= 1'b1;
            state    <= WR_IDLE;
          end else if (pop) begin
            first_beat <= 1'b0;
            line_q     <= line_cur + LINE_IDX_W'(slot_sum[WORD_IDX_W]);
            slot_q     <= slot_sum[WORD_IDX_W-1:0];
            tail_sent  <= (i_data.tag == TAG_TAIL);
          end
        end
        WR_DISCARD: begin
          // drop beats up to and including the tail
          if (pop && i_data.tag == TAG_TAIL) begin
            state <= WR_IDLE;
          end
        end
        default: begin
          state <= WR_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (beat_wr) begin
      bus.addr  <= line_cur;
      bus.wdata <= line_dbl[2*LINE_W-1 -: LINE_W];
      bus.wstrb <= strb_rot;
      bus.winc  <= wrap_mask & strb_rot;
    end
    if (o_wr_desc_rden) begin
      bus.int_addr <= i_wr_desc.addr.raw[30:0];
    end
  end

  assign bus.rden = 1'b0;

  // SRAM writes only while the port is granted
  a_wren_granted: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    bus.wren |-> bus.gnt);

endmodule

// File: dma_rd_engine.sv
// ####################
// DMA read engine
// streams an SRAM region out as tagged beats
// ####################

`timescale 1ns/100ps

module dma_rd_engine import dma_cfg_pkg::*, dma_desc_pkg::*; #(
  parameter int RD_FIFO_LIMIT = 100
) (
   input  logic          i_clk
  ,input  logic          i_rst_n
  ,input  dma_desc_t     i_rd_desc
  ,input  logic          i_rd_desc_empty
  ,output logic          o_rd_desc_rden
  ,input  logic [8:0]    i_pkt_usedw
  ,output pkt_beat_t     o_pkt_dout
  ,output logic          o_pkt_wren
  ,sram_req_if.engine    bus
);

  typedef enum logic [1:0] {RD_IDLE, RD_ISSUE, RD_WAIT} rd_state_t;

  rd_state_t           state;
  logic                desc_pending;
  logic                head_pending;
  dma_addr_u           cur_addr;
  logic [15:0]         remain;
  logic [15:0]         remain_m1;
  logic                room;
  logic                issue;
  logic                beat_in;
  logic                last_beat;
  logic [3:0]          byte_cnt;
  logic [1:0]          beat_tag;
  logic [3:0]          gran;
  logic [2*LINE_W-1:0] win_dbl;
  logic [BEAT_W-1:0]   win_le;
  logic [BEAT_W-1:0]   beat_be;

  // output FIFO fill limit
  assign room  = (i_pkt_usedw < 9'(RD_FIFO_LIMIT));
  assign issue = (state == RD_ISSUE) && bus.gnt && !desc_pending && room;
  assign beat_in = (state == RD_WAIT) && bus.rvalid;

  assign o_rd_desc_rden = (state == RD_ISSUE) && bus.gnt && desc_pending;

  assign last_beat = (remain <= 16'(BYTES_PER_BEAT));
  assign remain_m1 = remain - 16'd1;
  assign byte_cnt  = last_beat ? remain_m1[3:0] : 4'hf;
  assign beat_tag  = last_beat ? TAG_TAIL : (head_pending ? TAG_HEAD : TAG_BODY);

  // 2-byte granule of the start inside the returned window
  assign gran    = {cur_addr.f.word, cur_addr.f.bsel[1]};
  assign win_dbl = {bus.rdata, bus.rdata} >> (16 * gran);
  assign win_le  = win_dbl[BEAT_W-1:0];

  // back to packet order, pad past the end with zeros
  always_comb begin
    for (int j = 0; j < BEAT_W/8; j++) begin
      beat_be[BEAT_W-8-8*j +: 8] = (j <= int'(byte_cnt)) ? win_le[8*j +: 8] : 8'h00;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state        <= RD_IDLE;
      bus.req      <= 1'b0;
      bus.rden     <= 1'b0;
      bus.done     <= 1'b0;
      o_pkt_wren   <= 1'b0;
      desc_pending <= 1'b0;
      head_pending <= 1'b0;
      cur_addr     <= '0;
      remain       <= '0;
    end else begin
      bus.rden   <= issue;
      bus.done   <= 1'b0;
      o_pkt_wren <= beat_in;
      case (state)
        RD_IDLE: begin
          if (bus.req) begin
            bus.req <= 1'b0;
          end else if (!i_rd_desc_empty && room) begin
            bus.req      <= 1'b1;
            desc_pending <= 1'b1;
            state        <= RD_ISSUE;
          end
        end
        RD_ISSUE: begin
          if (o_rd_desc_rden) begin
            desc_pending <= 1'b0;
            head_pending <= 1'b1;
            cur_addr     <= i_rd_desc.addr;
            remain       <= i_rd_desc.len;
          end else if (issue) begin
            state <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          // one read outstanding, wait for its line
          if (bus.rvalid) begin
            head_pending <= 1'b0;
            cur_addr.raw <= cur_addr.raw + 32'(BYTES_PER_BEAT);
            remain       <= remain - 16'(BYTES_PER_BEAT);
            if (last_beat) begin
              bus.done <= 1'b1;
              state    <= RD_IDLE;
            end else begin
              state <= RD_ISSUE;
            end
          end
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_rd_desc_rden) begin
      bus.int_addr <= i_rd_desc.addr.raw[30:0];
    end
    // words below the start word come from the next line
    if (issue) begin
      bus.addr <= cur_addr.f.line;
      bus.winc <= (WORDS_PER_LINE'(1) << cur_addr.f.word) - WORDS_PER_LINE'(1);
    end
    if (beat_in) begin
      o_pkt_dout.tag  <= beat_tag;
      o_pkt_dout.cnt  <= byte_cnt;
      o_pkt_dout.data <= beat_be;
    end
  end

  assign bus.wren  = 1'b0;
  assign bus.wdata = '0;
  assign bus.wstrb = '0;

  a_rvalid_outstanding: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    bus.rvalid |-> state == RD_WAIT);

endmodule

// File: sram_port_arbiter.sv
// ####################
// SRAM port arbiter
// one engine at a time, write first, raises the interrupt
// ####################

`timescale 1ns/100ps

module sram_port_arbiter import dma_cfg_pkg::*, dma_desc_pkg::*; (
   input  logic                      i_clk
  ,input  logic                      i_rst_n
  ,sram_req_if.arbiter               wr
  ,sram_req_if.arbiter               rd
  ,output logic                      o_dma_rden
  ,output logic                      o_dma_wren
  ,output logic [31:0]               o_dma_addr
  ,output logic [LINE_W-1:0]         o_dma_wdata
  ,output logic [WORDS_PER_LINE-1:0] o_dma_wstrb
  ,output logic [WORDS_PER_LINE-1:0] o_dma_winc
  ,input  logic [LINE_W-1:0]         i_dma_rdata
  ,input  logic                      i_dma_rvalid
  ,output int_word_t                 o_din_int
  ,output logic                      o_wren_int
);

  typedef enum logic [1:0] {OWN_NONE, OWN_WR, OWN_RD} owner_t;

  owner_t owner;
  logic   wr_fin;
  logic   rd_fin;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      owner <= OWN_NONE;
    end else begin
      case (owner)
        OWN_NONE: begin
          // write engine wins a tie
          if (wr.req) begin
            owner <= OWN_WR;
          end else if (rd.req) begin
            owner <= OWN_RD;
          end
        end
        OWN_WR:  if (!wr.req) owner <= OWN_NONE;
        OWN_RD:  if (!rd.req) owner <= OWN_NONE;
        default: owner <= OWN_NONE;
      endcase
    end
  end

  assign wr.gnt = (owner == OWN_WR) && wr.req;
  assign rd.gnt = (owner == OWN_RD) && rd.req;

  // port follows the owner, quiet otherwise
  always_comb begin
    o_dma_rden  = 1'b0;
    o_dma_wren  = 1'b0;
    o_dma_addr  = '0;
    o_dma_wdata = '0;
    o_dma_wstrb = '0;
    o_dma_winc  = '0;
    case (owner)
      OWN_WR: begin
        o_dma_rden  = wr.rden;
        o_dma_wren  = wr.wren;
        o_dma_addr  = 32'(wr.addr);
        o_dma_wdata = wr.wdata;
        o_dma_wstrb = wr.wstrb;
        o_dma_winc  = wr.winc;
      end
      OWN_RD: begin
        o_dma_rden  = rd.rden;
        o_dma_wren  = rd.wren;
        o_dma_addr  = 32'(rd.addr);
        o_dma_wdata = rd.wdata;
        o_dma_wstrb = rd.wstrb;
        o_dma_winc  = rd.winc;
      end
      default: begin
      end
    endcase
  end

  // read data goes to the read engine only
  assign rd.rdata  = i_dma_rdata;
  assign rd.rvalid = i_dma_rvalid && (owner == OWN_RD);
  assign wr.rdata  = '0;
  assign wr.rvalid = 1'b0;

  assign wr_fin = (owner == OWN_WR) && wr.done;
  assign rd_fin = (owner == OWN_RD) && rd.done;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wren_int <= 1'b0;
    end else begin
      o_wren_int <= wr_fin || rd_fin;
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_fin) begin
      o_din_int <= '{wr_flag: 1'b1, addr: wr.int_addr};
    end else if (rd_fin) begin
      o_din_int <= '{wr_flag: 1'b0, addr: rd.int_addr};
    end
  end

  a_wr_owner: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (wr.wren || wr.rden) |-> owner == OWN_WR);
  a_rd_owner: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (rd.wren || rd.rden) |-> owner == OWN_RD);

endmodule

// File: pkt_dma_top.sv
// ####################
// packet DMA top level
// write engine, read engine and SRAM port arbiter
// ####################

`timescale 1ns/100ps

module pkt_dma_top import dma_cfg_pkg::*; #(
  parameter int RD_FIFO_LIMIT = 100
) (
   input  logic                      i_clk
  ,input  logic                      i_rst_n
  // packet data in
  ,input  logic                      i_empty_data
  ,output logic                      o_data_rden
  ,input  logic [PKT_W-1:0]          i_data
  // descriptor FIFOs
  ,input  logic [47:0]               i_wr_desc
  ,input  logic                      i_wr_desc_empty
  ,output logic                      o_wr_desc_rden
  ,input  logic [63:0]               i_rd_desc
  ,input  logic                      i_rd_desc_empty
  ,output logic                      o_rd_desc_rden
  // data SRAM
  ,output logic                      o_dma_rden
  ,output logic                      o_dma_wren
  ,output logic [31:0]               o_dma_addr
  ,output logic [LINE_W-1:0]         o_dma_wdata
  ,output logic [WORDS_PER_LINE-1:0] o_dma_wstrb
  ,output logic [WORDS_PER_LINE-1:0] o_dma_winc
  ,input  logic [LINE_W-1:0]         i_dma_rdata
  ,input  logic                      i_dma_rvalid
  // packet data out
  ,output logic [PKT_W-1:0]          o_pkt_dout
  ,output logic                      o_pkt_wren
  ,input  logic [8:0]                i_pkt_usedw
  // completion interrupt
  ,output logic [31:0]               o_din_int
  ,output logic                      o_wren_int
);

  sram_req_if wr_bus ();
  sram_req_if rd_bus ();

  dma_wr_engine u_wr (
     .i_clk           (i_clk)
    ,.i_rst_n         (i_rst_n)
    ,.i_empty_data    (i_empty_data)
    ,.o_data_rden     (o_data_rden)
    ,.i_data          (i_data)
    ,.i_wr_desc       (i_wr_desc)
    ,.i_wr_desc_empty (i_wr_desc_empty)
    ,.o_wr_desc_rden  (o_wr_desc_rden)
    ,.bus             (wr_bus)
  );

  // descriptor sits in the low 48 bits of the read entry
  dma_rd_engine #(
    .RD_FIFO_LIMIT (RD_FIFO_LIMIT)
  ) u_rd (
     .i_clk           (i_clk)
    ,.i_rst_n         (i_rst_n)
    ,.i_rd_desc       (i_rd_desc[47:0])
    ,.i_rd_desc_empty (i_rd_desc_empty)
    ,.o_rd_desc_rden  (o_rd_desc_rden)
    ,.i_pkt_usedw     (i_pkt_usedw)
    ,.o_pkt_dout      (o_pkt_dout)
    ,.o_pkt_wren      (o_pkt_wren)
    ,.bus             (rd_bus)
  );

  sram_port_arbiter u_arb (
     .i_clk        (i_clk)
    ,.i_rst_n      (i_rst_n)
    ,.wr           (wr_bus)
    ,.rd           (rd_bus)
    ,.o_dma_rden   (o_dma_rden)
    ,.o_dma_wren   (o_dma_wren)
    ,.o_dma_addr   (o_dma_addr)
    ,.o_dma_wdata  (o_dma_wdata)
    ,.o_dma_wstrb  (o_dma_wstrb)
    ,.o_dma_winc   (o_dma_winc)
    ,.i_dma_rdata  (i_dma_rdata)
    ,.i_dma_rvalid (i_dma_rvalid)
    ,.o_din_int    (o_din_int)
    ,.o_wren_int   (o_wren_int)
  );

endmodule

// File: tb_sram_model.sv
// ####################
// behavioral 256-bit data SRAM
// per-word line increment, variable read latency
// ####################

`timescale 1ns/100ps

module tb_sram_model import dma_cfg_pkg::*; #(
  parameter int LINES = 64
) (
   input  logic                      i_clk
  ,input  logic                      i_rst_n
  ,input  logic                      i_rden
  ,input  logic                      i_wren
  ,input  logic [31:0]               i_addr
  ,input  logic [LINE_W-1:0]         i_wdata
  ,input  logic [WORDS_PER_LINE-1:0] i_wstrb
  ,input  logic [WORDS_PER_LINE-1:0] i_winc
  ,input  logic [2:0]                i_lat
  ,output logic [LINE_W-1:0]         o_rdata
  ,output logic                      o_rvalid
);

  logic [LINE_W-1:0] mem [LINES];
  logic [LINE_W-1:0] pend_line;
  logic [2:0]        wait_cnt;

  // start pattern, every address bit takes part
  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a) ^ {3'(a >> 8), 3'(a >> 8), 2'(a >> 8)};
  endfunction

  // word w may refer to the next line
  function automatic int line_of(input logic [31:0] addr, input logic inc);
    return int'((addr + 32'(inc)) % LINES);
  endfunction

  always @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int a = 0; a < LINES * 32; a++) begin
        mem[a / 32][8 * (a % 32) +: 8] <= fill_byte(a);
      end
      pend_line <= '0;
      wait_cnt  <= '0;
      o_rdata   <= '0;
      o_rvalid  <= 1'b0;
    end else begin
      o_rvalid <= 1'b0;
      if (i_wren) begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
          if (i_wstrb[w]) begin
            mem[line_of(i_addr, i_winc[w])][32 * w +: 32] <= i_wdata[32 * w +: 32];
          end
        end
      end
      if (i_rden) begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
          pend_line[32 * w +: 32] <= mem[line_of(i_addr, i_winc[w])][32 * w +: 32];
        end
        wait_cnt <= i_lat;
      end else if (wait_cnt != 0) begin
        // line comes back after the latency count
        wait_cnt <= wait_cnt - 3'd1;
        if (wait_cnt == 3'd1) begin
          o_rvalid <= 1'b1;
          o_rdata  <= pend_line;
        end
      end
    end
  end

endmodule

// File: tb_pkt_dma.sv
// ####################
// packet DMA testbench
// job table, FIFO models, shadow memory checks
// ####################

`timescale 1ns/100ps

module tb_pkt_dma import dma_cfg_pkg::*, dma_desc_pkg::*; ();

  localparam int LIMIT     = 100;
  localparam int MEM_BYTES = 2048;

  typedef enum {JOB_WR, JOB_DISCARD, JOB_RD, JOB_PAIR} job_kind_t;

  typedef struct {
    job_kind_t   kind;
    logic [31:0] addr;
    int          len;
    int          fill;
  } job_t;

  logic                      i_clk           = 1'b0;
  logic                      i_rst_n         = 1'b0;
  logic                      i_empty_data    = 1'b1;
  pkt_beat_t                 i_data          = '0;
  dma_desc_t                 i_wr_desc       = '0;
  logic                      i_wr_desc_empty = 1'b1;
  logic [63:0]               i_rd_desc       = '0;
  logic                      i_rd_desc_empty = 1'b1;
  logic [8:0]                i_pkt_usedw     = '0;
  logic [2:0]                sram_lat        = 3'd1;
  logic                      o_data_rden;
  logic                      o_wr_desc_rden;
  logic                      o_rd_desc_rden;
  logic                      o_dma_rden;
  logic                      o_dma_wren;
  logic [31:0]               o_dma_addr;
  logic [LINE_W-1:0]         o_dma_wdata;
  logic [WORDS_PER_LINE-1:0] o_dma_wstrb;
  logic [WORDS_PER_LINE-1:0] o_dma_winc;
  logic [LINE_W-1:0]         i_dma_rdata;
  logic                      i_dma_rvalid;
  pkt_beat_t                 o_pkt_dout;
  logic                      o_pkt_wren;
  int_word_t                 o_din_int;
  logic                      o_wren_int;

  job_t        jobs [7];
  pkt_beat_t   data_q [$];
  dma_desc_t   wdesc_q [$];
  dma_desc_t   rdesc_q [$];
  pkt_beat_t   exp_beats [$];
  int_word_t   exp_ints [$];
  logic [7:0]  shadow [MEM_BYTES];
  logic        hold_out   = 1'b0;
  logic        take_data  = 1'b0;
  logic        take_wdesc = 1'b0;
  logic        take_rdesc = 1'b0;
  logic [31:0] data_state = 32'h1163_4311;
  logic [31:0] lat_state  = 32'h1163_4311;
  int          cycles     = 0;
  int          cycle_limit;

  pkt_dma_top #(
    .RD_FIFO_LIMIT (LIMIT)
  ) u_dut (
     .i_clk           (i_clk)
    ,.i_rst_n         (i_rst_n)
    ,.i_empty_data    (i_empty_data)
    ,.o_data_rden     (o_data_rden)
    ,.i_data          (i_data)
    ,.i_wr_desc       (i_wr_desc)
    ,.i_wr_desc_empty (i_wr_desc_empty)
    ,.o_wr_desc_rden  (o_wr_desc_rden)
    ,.i_rd_desc       (i_rd_desc)
    ,.i_rd_desc_empty (i_rd_desc_empty)
    ,.o_rd_desc_rden  (o_rd_desc_rden)
    ,.o_dma_rden      (o_dma_rden)
    ,.o_dma_wren      (o_dma_wren)
    ,.o_dma_addr      (o_dma_addr)
    ,.o_dma_wdata     (o_dma_wdata)
    ,.o_dma_wstrb     (o_dma_wstrb)
    ,.o_dma_winc      (o_dma_winc)
    ,.i_dma_rdata     (i_dma_rdata)
    ,.i_dma_rvalid    (i_dma_rvalid)
    ,.o_pkt_dout      (o_pkt_dout)
    ,.o_pkt_wren      (o_pkt_wren)
    ,.i_pkt_usedw     (i_pkt_usedw)
    ,.o_din_int       (o_din_int)
    ,.o_wren_int      (o_wren_int)
  );

  tb_sram_model u_mem (
     .i_clk    (i_clk)
    ,.i_rst_n  (i_rst_n)
    ,.i_rden   (o_dma_rden)
    ,.i_wren   (o_dma_wren)
    ,.i_addr   (o_dma_addr)
    ,.i_wdata  (o_dma_wdata)
    ,.i_wstrb  (o_dma_wstrb)
    ,.i_winc   (o_dma_winc)
    ,.i_lat    (sram_lat)
    ,.o_rdata  (i_dma_rdata)
    ,.o_rvalid (i_dma_rvalid)
  );

  always #50 i_clk = ~i_clk;

  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  function automatic int job_beats(input job_t job);
    return ((job.len + 15) / 16) * ((job.kind == JOB_PAIR) ? 2 : 1);
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_beat(input pkt_beat_t got, input pkt_beat_t exp);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH o_pkt_dout got %h expected %h", got, exp));
    end
  endtask

  task automatic check_int(input int_word_t got, input int_word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH o_din_int got %h expected %h", got, exp));
    end
  endtask

  task automatic check_mem(input int idx, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("MISMATCH sram word %h got %h expected %h", idx, got, exp));
    end
  endtask

  // pops seen at the rising edge
  always @(posedge i_clk) begin
    take_data  <= o_data_rden;
    take_wdesc <= o_wr_desc_rden;
    take_rdesc <= o_rd_desc_rden;
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      stop_run("timeout: jobs did not finish within the cycle limit");
    end
  end

  // outputs checked before FIFO heads and latency are driven
  always @(negedge i_clk) begin
    if (o_pkt_wren) begin
      if (hold_out) begin
        stop_run("output beat written while the output FIFO was at its limit");
      end else if (exp_beats.size() == 0) begin
        stop_run("output beat written with none expected");
      end else begin
        check_beat(o_pkt_dout, exp_beats.pop_front());
      end
    end
    if (o_wren_int) begin
      if (exp_ints.size() == 0) begin
        stop_run("interrupt raised with none expected");
      end else begin
        check_int(o_din_int, exp_ints.pop_front());
      end
    end
    if (take_data) begin
      if (data_q.size() == 0) begin
        stop_run("data FIFO read while empty");
      end else begin
        void'(data_q.pop_front());
      end
    end
    if (take_wdesc) begin
      if (wdesc_q.size() == 0) begin
        stop_run("write descriptor FIFO read while empty");
      end else begin
        void'(wdesc_q.pop_front());
      end
    end
    if (take_rdesc) begin
      if (rdesc_q.size() == 0) begin
        stop_run("read descriptor FIFO read while empty");
      end else begin
        void'(rdesc_q.pop_front());
      end
    end
    i_empty_data    = (data_q.size() == 0);
    i_data          = (data_q.size() != 0) ? data_q[0] : '0;
    i_wr_desc_empty = (wdesc_q.size() == 0);
    i_wr_desc       = (wdesc_q.size() != 0) ? wdesc_q[0] : '0;
    i_rd_desc_empty = (rdesc_q.size() == 0);
    i_rd_desc       = (rdesc_q.size() != 0) ? {16'h0, rdesc_q[0]} : '0;
    // 1 to 4 cycles
    sram_lat = 3'd1 + 3'(lcg_next(lat_state) >> 30);
  end

  // packet byte i lands at addr + i
  task automatic queue_write(input logic [31:0] addr, input int len);
    pkt_beat_t beat;
    dma_desc_t desc;
    int_word_t iw;
    int        nbeats;
    int        words;
    nbeats = (len + 15) / 16;
    for (int b = 0; b < nbeats; b++) begin
      words    = (len - 16 * b >= 16) ? 4 : (len - 16 * b) / 4;
      beat.tag = (b == 0) ? TAG_HEAD : ((b == nbeats - 1) ? TAG_TAIL : TAG_BODY);
      beat.cnt = {2'(words - 1), 2'b00};
      for (int k = 0; k < WORDS_PER_BEAT; k++) begin
        beat.data[32 * k +: 32] = lcg_next(data_state);
      end
      for (int i = 0; i < 4 * words; i++) begin
        shadow[addr + 16 * b + i] = beat.data[BEAT_W - 1 - 8 * i -: 8];
      end
      data_q.push_back(beat);
    end
    desc.len      = 16'(len);
    desc.addr.raw = addr;
    wdesc_q.push_back(desc);
    iw.wr_flag = 1'b1;
    iw.addr    = addr[30:0];
    exp_ints.push_back(iw);
  endtask

  // no head tag so nothing reaches memory
  task automatic queue_discard(input int len);
    pkt_beat_t beat;
    int        nbeats;
    nbeats = (len + 15) / 16;
    for (int b = 0; b < nbeats; b++) begin
      beat.tag  = (b == nbeats - 1) ? TAG_TAIL : TAG_BODY;
      beat.cnt  = 4'hc;
      beat.data = {lcg_next(data_state), lcg_next(data_state),
                   lcg_next(data_state), lcg_next(data_state)};
      data_q.push_back(beat);
    end
  endtask

  task automatic queue_read(input logic [31:0] addr, input int len);
    pkt_beat_t beat;
    dma_desc_t desc;
    int_word_t iw;
    int        nbeats;
    int        left;
    nbeats = (len + 15) / 16;
    for (int b = 0; b < nbeats; b++) begin
      left      = len - 16 * b;
      beat.tag  = (b == nbeats - 1) ? TAG_TAIL : ((b == 0) ? TAG_HEAD : TAG_BODY);
      beat.cnt  = (left >= 16) ? 4'hf : 4'(left - 1);
      beat.data = '0;
      for (int j = 0; j < 16; j++) begin
        if (j < left) begin
          beat.data[BEAT_W - 1 - 8 * j -: 8] = shadow[addr + 16 * b + j];
        end
      end
      exp_beats.push_back(beat);
    end
    desc.len      = 16'(len);
    desc.addr.raw = addr;
    rdesc_q.push_back(desc);
    iw.wr_flag = 1'b0;
    iw.addr    = addr[30:0];
    exp_ints.push_back(iw);
  endtask

  task automatic wait_done();
    while (exp_ints.size() != 0 || exp_beats.size() != 0 || data_q.size() != 0) begin
      @(negedge i_clk);
    end
    // catch late strays
    repeat (3) @(negedge i_clk);
  endtask

  task automatic check_memory();
    logic [31:0] exp;
    for (int i = 0; i < MEM_BYTES / 4; i++) begin
      exp = {shadow[4 * i + 3], shadow[4 * i + 2], shadow[4 * i + 1], shadow[4 * i]};
      check_mem(i, u_mem.mem[i / 8][32 * (i % 8) +: 32], exp);
    end
  endtask

  task automatic run_job(input job_t job);
    i_pkt_usedw = 9'(job.fill);
    case (job.kind)
      JOB_WR:      queue_write(job.addr, job.len);
      JOB_DISCARD: queue_discard(job.len);
      JOB_RD: begin
        hold_out = (job.fill >= LIMIT);
        queue_read(job.addr, job.len);
        if (hold_out) begin
          repeat (20) @(negedge i_clk);
          hold_out    = 1'b0;
          i_pkt_usedw = '0;
        end
      end
      default: begin
        // write goes first when both are pending
        queue_write(job.addr, job.len);
        queue_read(job.addr + 32'd2, job.len - 1);
      end
    endcase
    wait_done();
    check_memory();
  endtask

  initial begin
    jobs[0] = '{JOB_WR,      32'h040, 48, 0};
    jobs[1] = '{JOB_WR,      32'h098, 40, 0};
    jobs[2] = '{JOB_DISCARD, 32'h000, 32, 0};
    jobs[3] = '{JOB_RD,      32'h09a, 37, 37};
    jobs[4] = '{JOB_RD,      32'h1fa, 11, 0};
    jobs[5] = '{JOB_RD,      32'h040, 48, LIMIT};
    jobs[6] = '{JOB_PAIR,    32'h300, 24, 0};
    cycle_limit = 0;
    foreach (jobs[j]) begin
      cycle_limit += job_beats(jobs[j]) * 8 + 20;
    end

    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    // shadow starts from the model's fill pattern
    for (int a = 0; a < MEM_BYTES; a++) begin
      shadow[a] = u_mem.mem[a / 32][8 * (a % 32) +: 8];
    end

    foreach (jobs[j]) begin
      run_job(jobs[j]);
    end

    if (exp_beats.size() == 0 && exp_ints.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_run("results still outstanding at the end of the run");
    end
  end

endmodule

// File: tb.f
dma_cfg_pkg.sv
dma_desc_pkg.sv
sram_req_if.sv
dma_wr_engine.sv
dma_rd_engine.sv
sram_port_arbiter.sv
pkt_dma_top.sv
tb_sram_model.sv
tb_pkt_dma.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         ?= tb_pkt_dma
RTL_TOP     ?= pkt_dma_top
FILELIST    ?= tb.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS  ?= -Wall
PASS_TEXT   ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
